/* verilog/jtag_ctrlport_pkg.sv */
package jtag_ctrlport_pkg;

  // --------------------------------------------------------------------------
  // controlport bus and register window
  // --------------------------------------------------------------------------
  localparam int ctrlport_addr_w = 20;
  localparam int ctrlport_data_w = 32;

  localparam logic [ctrlport_addr_w-1:0] jtag_base_addr = 20'h0_0000;
  // window size in byte addresses
  localparam int jtag_num_addr = 32;

  // byte offsets inside the window
  localparam logic [ctrlport_addr_w-1:0] reg_tx_data  = 20'h0_0000;
  localparam logic [ctrlport_addr_w-1:0] reg_stb_data = 20'h0_0004;
  localparam logic [ctrlport_addr_w-1:0] reg_control  = 20'h0_0008;
  localparam logic [ctrlport_addr_w-1:0] reg_rx_data  = 20'h0_000C;

  // --------------------------------------------------------------------------
  // control register fields
  // --------------------------------------------------------------------------
  localparam int prescalar_w = 8;
  localparam int length_w    = 5;
  localparam int shift_w     = 32;

  localparam int prescalar_lsb = 0;
  localparam int prescalar_msb = prescalar_lsb + prescalar_w - 1;
  // length holds bit count minus one
  localparam int length_lsb = 8;
  localparam int length_msb = length_lsb + length_w - 1;
  // same bit position, write side and read side
  localparam int reset_bit = 31;
  localparam int ready_bit = 31;

  localparam logic [prescalar_w-1:0] default_prescalar = 8'd1;

  // response status codes
  typedef enum logic [1:0] {sts_okay, sts_cmderr, sts_slverr, sts_ackerr} ctrl_status_t;

  // bit-queue engine states
  typedef enum logic [1:0] {st_idle, st_low, st_high} bitq_state_t;

endpackage

/* verilog/bitq_if.sv */
`timescale 1ns/1ps

interface bitq_if;
  import jtag_ctrlport_pkg::*;

  // one-cycle strobes from the register block
  logic start;
  logic soft_rst;

  // transfer settings, held stable while ready is low
  logic [prescalar_w-1:0] prescalar;
  logic [length_w-1:0]    len;
  logic [shift_w-1:0]     wr_data;
  logic [shift_w-1:0]     stb_data;

  // engine status and captured tdo bits
  logic               ready;
  logic [shift_w-1:0] rd_data;

  // register block side
  modport regs (
    output start, soft_rst, prescalar, len, wr_data, stb_data,
    input  ready, rd_data
  );

  // engine side
  modport engine (
    input  start, soft_rst, prescalar, len, wr_data, stb_data,
    output ready, rd_data
  );

endinterface

/* verilog/ctrlport_to_jtag.sv */
`timescale 1ns/1ps

module ctrlport_to_jtag (
  input  logic                                         ctrlport_clk,
  input  logic                                         ctrlport_rst,
  // controlport slave
  input  logic                                         s_ctrlport_req_wr,
  input  logic                                         s_ctrlport_req_rd,
  input  logic [jtag_ctrlport_pkg::ctrlport_addr_w-1:0] s_ctrlport_req_addr,
  input  logic [jtag_ctrlport_pkg::ctrlport_data_w-1:0] s_ctrlport_req_data,
  output logic                                         s_ctrlport_resp_ack,
  output jtag_ctrlport_pkg::ctrl_status_t               s_ctrlport_resp_status,
  output logic [jtag_ctrlport_pkg::ctrlport_data_w-1:0] s_ctrlport_resp_data,
  // towards the engine
  bitq_if.regs                                         bitq
);
  import jtag_ctrlport_pkg::*;

  // --------------------------------------------------------------------------
  // address decode
  // --------------------------------------------------------------------------
  logic                       addr_in_range;
  logic [ctrlport_addr_w-1:0] addr_offset;
  logic                       soft_rst_req;
  logic [ctrlport_data_w-1:0] control_word;

  // window check, upper bound exclusive
  assign addr_in_range = (s_ctrlport_req_addr >= jtag_base_addr) &&
                         (s_ctrlport_req_addr < jtag_base_addr + jtag_num_addr);
  assign addr_offset   = s_ctrlport_req_addr - jtag_base_addr;

  // reset bit set on a control write, accepted even while busy
  assign soft_rst_req = (addr_offset == reg_control) &&
                        s_ctrlport_req_data[reset_bit];

  // readback image of the control register
  always_comb begin
    control_word                             = '0;
    control_word[prescalar_msb:prescalar_lsb] = bitq.prescalar;
    control_word[length_msb:length_lsb]       = bitq.len;
    control_word[ready_bit]                   = bitq.ready;
  end

  // --------------------------------------------------------------------------
  // request handling, response one clock after the strobe
  // --------------------------------------------------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      s_ctrlport_resp_ack    <= 1'b0;
      s_ctrlport_resp_status <= sts_okay;
      s_ctrlport_resp_data   <= '0;
      bitq.start             <= 1'b0;
      bitq.soft_rst          <= 1'b0;
      bitq.prescalar         <= default_prescalar;
      bitq.len               <= '0;
      bitq.wr_data           <= '0;
      bitq.stb_data          <= '0;
    end else begin
      // strobes last one cycle
      bitq.start    <= 1'b0;
      bitq.soft_rst <= 1'b0;
      s_ctrlport_resp_ack    <= 1'b0;
      s_ctrlport_resp_status <= sts_okay;
      s_ctrlport_resp_data   <= '0;

      if (s_ctrlport_req_wr && addr_in_range) begin
        s_ctrlport_resp_ack <= 1'b1;
        if (soft_rst_req) begin
          // abort, settings left untouched
          bitq.soft_rst <= 1'b1;
        end else if (!bitq.ready) begin
          // busy, drop the write
          s_ctrlport_resp_status <= sts_cmderr;
        end else begin
          case (addr_offset)
            reg_tx_data: begin
              bitq.wr_data <= s_ctrlport_req_data;
            end
            reg_stb_data: begin
              bitq.stb_data <= s_ctrlport_req_data;
            end
            reg_control: begin
              bitq.prescalar <= s_ctrlport_req_data[prescalar_msb:prescalar_lsb];
              bitq.len       <= s_ctrlport_req_data[length_msb:length_lsb];
              // reset bit clear here, so kick off a transfer
              bitq.start     <= 1'b1;
            end
            default: begin
              s_ctrlport_resp_status <= sts_cmderr;
            end
          endcase
        end
      end else if (s_ctrlport_req_rd && addr_in_range) begin
        s_ctrlport_resp_ack <= 1'b1;
        case (addr_offset)
          reg_rx_data: begin
            s_ctrlport_resp_data <= bitq.rd_data;
          end
          reg_control: begin
            s_ctrlport_resp_data <= control_word;
          end
          // write-only and unused offsets
          default: begin
            s_ctrlport_resp_status <= sts_cmderr;
          end
        endcase
      end
      // out of range: stay silent, no ack
    end
  end

endmodule

/* verilog/bitq_fsm.sv */
`timescale 1ns/1ps

module bitq_fsm (
  input  logic      ctrlport_clk,
  input  logic      ctrlport_rst,
  // settings and status towards the register block
  bitq_if.engine    bitq,
  // jtag pins
  output logic      tck,
  output logic      tdi,
  output logic      tms,
  input  logic      tdo
);
  import jtag_ctrlport_pkg::*;

  // --------------------------------------------------------------------------
  // state and counters
  // --------------------------------------------------------------------------
  bitq_state_t            state;
  // clocks spent in the current phase
  logic [prescalar_w-1:0] div_cnt;
  // index of the bit on the wire
  logic [length_w-1:0]    bit_cnt;
  // working copies of tdi and tms data
  logic [shift_w-1:0]     tx_sh;
  logic [shift_w-1:0]     tms_sh;

  logic phase_done;

  // a phase lasts prescalar+1 clocks
  assign phase_done = (div_cnt == bitq.prescalar);

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      state        <= st_idle;
      div_cnt      <= '0;
      bit_cnt      <= '0;
      tx_sh        <= '0;
      tms_sh       <= '0;
      bitq.rd_data <= '0;
    end else if (bitq.soft_rst) begin
      // abort, keep captured data for readback
      state   <= st_idle;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (bitq.start) begin
            state        <= st_low;
            div_cnt      <= '0;
            bit_cnt      <= '0;
            tx_sh        <= bitq.wr_data;
            tms_sh       <= bitq.stb_data;
            bitq.rd_data <= '0;
          end
        end

        // tck low, tdi/tms settle
        st_low: begin
          if (phase_done) begin
            div_cnt <= '0;
            state   <= st_high;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end

        // tck high, tdo taken on the first clock
        st_high: begin
          if (div_cnt == '0) begin
            bitq.rd_data[bit_cnt] <= tdo;
          end
          if (phase_done) begin
            div_cnt <= '0;
            if (bit_cnt == bitq.len) begin
              state <= st_idle;
            end else begin
              // next bit shows up as the low phase begins
              state   <= st_low;
              bit_cnt <= bit_cnt + 1'b1;
              tx_sh   <= tx_sh >> 1;
              tms_sh  <= tms_sh >> 1;
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // outputs
  // --------------------------------------------------------------------------
  // tck idles low, high only in the high phase
  assign tck = (state == st_high);

  // lsb first
  assign tdi = tx_sh[0];
  assign tms = tms_sh[0];

  assign bitq.ready = (state == st_idle);

endmodule

/* verilog/jtag_ctrlport_top.sv */
`timescale 1ns/1ps

module jtag_ctrlport_top (
  input  logic                                         ctrlport_clk,
  input  logic                                         ctrlport_rst,
  // controlport slave
  input  logic                                         s_ctrlport_req_wr,
  input  logic                                         s_ctrlport_req_rd,
  input  logic [jtag_ctrlport_pkg::ctrlport_addr_w-1:0] s_ctrlport_req_addr,
  input  logic [jtag_ctrlport_pkg::ctrlport_data_w-1:0] s_ctrlport_req_data,
  output logic                                         s_ctrlport_resp_ack,
  output jtag_ctrlport_pkg::ctrl_status_t               s_ctrlport_resp_status,
  output logic [jtag_ctrlport_pkg::ctrlport_data_w-1:0] s_ctrlport_resp_data,
  // jtag pins
  output logic                                         tck,
  output logic                                         tdi,
  output logic                                         tms,
  input  logic                                         tdo
);

  // settings, strobes and result between the two blocks
  bitq_if bitq ();

  // register window
  ctrlport_to_jtag i_regs (
    .ctrlport_clk           (ctrlport_clk),
    .ctrlport_rst           (ctrlport_rst),
    .s_ctrlport_req_wr      (s_ctrlport_req_wr),
    .s_ctrlport_req_rd      (s_ctrlport_req_rd),
    .s_ctrlport_req_addr    (s_ctrlport_req_addr),
    .s_ctrlport_req_data    (s_ctrlport_req_data),
    .s_ctrlport_resp_ack    (s_ctrlport_resp_ack),
    .s_ctrlport_resp_status (s_ctrlport_resp_status),
    .s_ctrlport_resp_data   (s_ctrlport_resp_data),
    .bitq                   (bitq)
  );

  // bit-queue engine on the pins
  bitq_fsm i_engine (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .bitq         (bitq),
    .tck          (tck),
    .tdi          (tdi),
    .tms          (tms),
    .tdo          (tdo)
  );

endmodule

/* testbench/jtag_target_model.sv */
`timescale 1ns/1ps

module jtag_target_model (
  input  logic        ctrlport_clk,
  input  logic        clear,
  input  logic [31:0] pattern,
  input  logic        tck,
  input  logic        tdi,
  input  logic        tms,
  output logic        tdo,
  output logic [31:0] cap_tdi,
  output logic [31:0] cap_tms,
  output logic [5:0]  bits,
  output logic [8:0]  half_period
);
  // clocks seen so far with tck high
  logic [8:0] high_cnt;

  // bit counter starts at 0 so tdo is known before the first clear
  initial bits = '0;

  // bit index is the count of falling tck edges
  assign tdo = pattern[bits[4:0]];

  // target samples tdi and tms on rising tck
  always @(posedge tck) begin
    cap_tdi[bits[4:0]] <= tdi;
    cap_tms[bits[4:0]] <= tms;
  end

  // one step per finished bit
  always @(negedge tck or posedge clear) begin
    if (clear) begin
      bits <= '0;
    end else begin
      bits <= bits + 1'b1;
    end
  end

  // count clocks in each high phase and keep the count when tck falls
  always @(posedge ctrlport_clk) begin
    if (clear) begin
      high_cnt    <= '0;
      half_period <= '0;
    end else if (tck) begin
      high_cnt <= high_cnt + 1'b1;
    end else if (high_cnt != 0) begin
      half_period <= high_cnt;
      high_cnt    <= '0;
    end
  end

endmodule

/* testbench/tb_jtag_ctrlport.sv */
`timescale 1ns/1ps

module tb_jtag_ctrlport;
  import jtag_ctrlport_pkg::*;

  localparam int max_tests = 32;
  // words per golden record
  localparam int rec_w = 8;

  logic                       ctrlport_clk;
  logic                       ctrlport_rst;
  logic                       req_wr;
  logic                       req_rd;
  logic [ctrlport_addr_w-1:0] req_addr;
  logic [ctrlport_data_w-1:0] req_data;
  logic                       resp_ack;
  ctrl_status_t               resp_status;
  logic [ctrlport_data_w-1:0] resp_data;
  logic                       tck, tdi, tms, tdo;
  logic                       target_clear;
  logic [31:0]                tdo_pattern, cap_tdi, cap_tms;
  logic [5:0]                 cap_bits;
  logic [8:0]                 half_period;

  logic [31:0] golden [0:max_tests*rec_w-1];
  int          num_tests, errors, checks, failed_tests, limit_clocks;
  bit          loaded;

  initial ctrlport_clk = 1'b0;
  always #5 ctrlport_clk = ~ctrlport_clk;

  jtag_ctrlport_top i_dut (
    .ctrlport_clk (ctrlport_clk), .ctrlport_rst (ctrlport_rst),
    .s_ctrlport_req_wr (req_wr), .s_ctrlport_req_rd (req_rd),
    .s_ctrlport_req_addr (req_addr), .s_ctrlport_req_data (req_data),
    .s_ctrlport_resp_ack (resp_ack), .s_ctrlport_resp_status (resp_status),
    .s_ctrlport_resp_data (resp_data),
    .tck (tck), .tdi (tdi), .tms (tms), .tdo (tdo)
  );

  jtag_target_model i_target (
    .ctrlport_clk (ctrlport_clk), .clear (target_clear), .pattern (tdo_pattern),
    .tck (tck), .tdi (tdi), .tms (tms), .tdo (tdo), .cap_tdi (cap_tdi),
    .cap_tms (cap_tms), .bits (cap_bits), .half_period (half_period)
  );

  // --------------------------------------------------------------------------
  // bus access helpers, all return 1 ns after a rising edge
  // --------------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic bus_cycle(input logic is_wr, input logic [19:0] addr,
                           input logic [31:0] data, output logic got_ack,
                           output logic [31:0] sts, output logic [31:0] rdata);
    @(posedge ctrlport_clk);
    #1;
    req_wr   = is_wr;
    req_rd   = !is_wr;
    req_addr = addr;
    req_data = data;
    @(posedge ctrlport_clk);
    #1;
    req_wr  = 1'b0;
    req_rd  = 1'b0;
    got_ack = 1'b0;
    sts     = '0;
    rdata   = '0;
    // ack expected one clock after the strobe, look up to 4 clocks
    for (int n = 0; n < 4 && !got_ack; n++) begin
      if (resp_ack) begin
        got_ack = 1'b1;
        sts     = resp_status;
        rdata   = resp_data;
      end else begin
        @(posedge ctrlport_clk);
        #1;
      end
    end
  endtask

  task automatic ctrl_write(input logic [19:0] addr, input logic [31:0] data,
                            output logic [31:0] sts);
    logic        got_ack;
    logic [31:0] rdata;
    bus_cycle(1'b1, addr, data, got_ack, sts, rdata);
    if (!got_ack) begin
      errors++;
      $display("no ack for the write to in-range address %h", addr);
    end
  endtask

  task automatic ctrl_read(input logic [19:0] addr, output logic [31:0] sts,
                           output logic [31:0] rdata);
    logic got_ack;
    bus_cycle(1'b0, addr, '0, got_ack, sts, rdata);
    if (!got_ack) begin
      errors++;
      $display("no ack for the read of in-range address %h", addr);
    end
  endtask

  // poll CONTROL until the ready bit comes back
  task automatic wait_ready();
    logic [31:0] sts, rdata;
    rdata = '0;
    for (int polls = 0; polls < 2000 && !rdata[ready_bit]; polls++) begin
      ctrl_read(jtag_base_addr + reg_control, sts, rdata);
    end
    if (!rdata[ready_bit]) begin
      errors++;
      $display("timed out waiting for the engine to report ready");
    end
  endtask

  task automatic load_data(input logic [31:0] tx, input logic [31:0] stb);
    logic [31:0] sts;
    ctrl_write(jtag_base_addr + reg_tx_data, tx, sts);
    check_value("tx write status", sts_okay, sts);
    ctrl_write(jtag_base_addr + reg_stb_data, stb, sts);
    check_value("stb write status", sts_okay, sts);
  endtask

  // clear the target, then a CONTROL write with reset clear starts the engine
  task automatic start_transfer(input logic [31:0] len, input logic [31:0] presc);
    logic [31:0] ctrl, sts;
    ctrl = '0;
    ctrl[length_msb:length_lsb]       = len[length_w-1:0];
    ctrl[prescalar_msb:prescalar_lsb] = presc[prescalar_w-1:0];
    target_clear = 1'b1;
    @(posedge ctrlport_clk);
    #1;
    target_clear = 1'b0;
    ctrl_write(jtag_base_addr + reg_control, ctrl, sts);
    check_value("control write status", sts_okay, sts);
  endtask

  // len+1 bits, lsb first, each high phase prescalar+1 clocks
  task automatic check_capture(input logic [31:0] tx, input logic [31:0] stb,
                               input logic [31:0] len, input logic [31:0] presc);
    logic [31:0] mask;
    mask = 32'hffff_ffff >> (5'd31 - len[4:0]);
    check_value("tdi bits", tx & mask, cap_tdi & mask);
    check_value("tms bits", stb & mask, cap_tms & mask);
    check_value("tck rising edges", len + 1, cap_bits);
    check_value("tck half period", presc + 1, half_period);
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] kind, a, b, len, presc, pat, exp_d, exp_s, sts, rdata;
    logic        got_ack;
    int          errs_before;
    ctrlport_rst = 1'b1;
    req_wr       = 1'b0;
    req_rd       = 1'b0;
    req_addr     = '0;
    req_data     = '0;
    target_clear = 1'b0;
    tdo_pattern  = '0;
    $readmemh("testbench/jtag_golden.txt", golden);
    // records up to the end marker, clock budget per record
    limit_clocks = 8;
    while (num_tests < max_tests && golden[num_tests*rec_w] >= 1 &&
           golden[num_tests*rec_w] <= 6) begin
      kind = golden[num_tests*rec_w];
      len = golden[num_tests*rec_w+3];
      presc = golden[num_tests*rec_w+4];
      limit_clocks += 50;
      if (kind >= 4) limit_clocks += (len + 1) * 2 * (presc + 1);
      // busy test runs two transfers
      if (kind == 5) limit_clocks += (len + 1) * 2 * (presc + 1) + 50;
      num_tests++;
    end
    if (num_tests == 0) begin
      errors++;
      $display("no tests found in testbench/jtag_golden.txt");
    end
    loaded = 1'b1;
    repeat (8) @(posedge ctrlport_clk);
    #1;
    ctrlport_rst = 1'b0;

    for (int rec = 0; rec < num_tests; rec++) begin
      {kind, a, b, len} = {golden[rec*rec_w], golden[rec*rec_w+1],
                           golden[rec*rec_w+2], golden[rec*rec_w+3]};
      {presc, pat, exp_d, exp_s} = {golden[rec*rec_w+4], golden[rec*rec_w+5],
                                    golden[rec*rec_w+6], golden[rec*rec_w+7]};
      errs_before = errors;
      case (kind)
        1: begin
          ctrl_read(jtag_base_addr + a, sts, rdata);
          check_value("resp_status", exp_s, sts);
          check_value("resp_data", exp_d, rdata);
        end
        2: begin
          ctrl_write(jtag_base_addr + a, b, sts);
          check_value("resp_status", exp_s, sts);
        end
        3: begin
          bus_cycle(1'b0, jtag_base_addr + a, '0, got_ack, sts, rdata);
          if (got_ack) begin
            errors++;
            $display("access outside the register window was acknowledged");
          end
        end
        4: begin
          load_data(a, b);
          tdo_pattern = pat;
          start_transfer(len, presc);
          wait_ready();
          check_capture(a, b, len, presc);
          ctrl_read(jtag_base_addr + reg_rx_data, sts, rdata);
          check_value("rx_data", exp_d, rdata);
        end
        5: begin
          load_data(a, b);
          start_transfer(len, presc);
          // engine busy, this tx write must be dropped
          ctrl_write(jtag_base_addr + reg_tx_data, exp_d, sts);
          check_value("busy write status", exp_s, sts);
          wait_ready();
          check_capture(a, b, len, presc);
          start_transfer(len, presc);
          wait_ready();
          check_capture(a, b, len, presc);
        end
        6: begin
          load_data(a, b);
          start_transfer(len, presc);
          repeat (10) @(posedge ctrlport_clk);
          ctrl_write(jtag_base_addr + reg_control, 32'h1 << reset_bit, sts);
          check_value("soft reset write status", exp_s, sts);
          ctrl_read(jtag_base_addr + reg_control, sts, rdata);
          check_value("control ready", 1, rdata[ready_bit]);
          // aborted engine keeps tck low
          repeat (20) begin
            @(posedge ctrlport_clk);
            #1;
            check_value("tck", 0, tck);
          end
        end
      endcase
      if (errors == errs_before) begin
        $display("test %0d kind %0d: ok", rec, kind);
      end else begin
        failed_tests++;
        $display("test %0d kind %0d: failed", rec, kind);
      end
    end

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             num_tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog sized from the transfer lengths in the golden file
  initial begin
    wait (loaded);
    repeat (limit_clocks) @(posedge ctrlport_clk);
    $display("watchdog expired after %0d clocks, the tests did not finish", limit_clocks);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* jtag_ctrlport.f */
verilog/jtag_ctrlport_pkg.sv
verilog/bitq_if.sv
verilog/ctrlport_to_jtag.sv
verilog/bitq_fsm.sv
verilog/jtag_ctrlport_top.sv
testbench/jtag_target_model.sv
testbench/tb_jtag_ctrlport.sv

/* testbench/jtag_golden.txt */
// kind addr_or_tx data_or_stb len prescalar tdo_pattern exp_data_or_rx exp_status
// kind 1 read, 2 write, 3 no-ack read, 4 transfer, 5 write while busy, 6 soft reset, 0 end
1 00008 00000000 00 00 00000000 80000001 0
4 000000a5 0000003c 07 00 0000005a 0000005a 0
4 12345678 0000ffff 0f 01 deadc3a5 0000c3a5 0
4 cafef00d 80000001 1f 05 13579bdf 13579bdf 0
4 00000001 00000001 00 02 ffffffff 00000001 0
1 00010 00000000 00 00 00000000 00000000 1
2 00014 deadbeef 00 00 00000000 00000000 1
1 00000 00000000 00 00 00000000 00000000 1
3 00040 00000000 00 00 00000000 00000000 0
5 0f0f0f0f 00000000 1f 03 00000000 f0f0f0f0 1
6 ffffffff 00000000 1f 07 00000000 00000000 0
1 00008 00000000 00 00 00000000 80001f07 0
0 00000 00000000 00 00 00000000 00000000 0
